// File: design/timer_pkg.sv
////////////////////
// shared types and timing constants for the countdown timer
// imported by the RTL and the testbench
////////////////////

package timer_pkg;

    // display width
    localparam int LED_W = 4;

    // time loaded when leaving idle
    localparam logic [LED_W-1:0] DEF_TIME = 4'b1000;

    // ticks spent flashing once the count hits zero
    localparam int FLASH_TICKS = 4;

    // clocks per second tick, kept small for simulation
    localparam int TICK_DIV = 64;

    // tick counter bit that drives the flash phase
    localparam int FLASH_BIT = 3;

    // clocks a synchronized button must hold before it is accepted
    localparam int DEB_COUNT = 8;

    // derived counter widths
    localparam int DEB_CNT_W = $clog2(DEB_COUNT + 1);
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam int FLASH_CNT_W = $clog2(FLASH_TICKS + 1);

    // timer FSM states
    typedef enum logic [2:0] {
        IDLE,       // led dark, waiting for ctrl
        INIT,       // one clock, loads DEF_TIME
        SET_TIME,   // 0 and 1 buttons shift into led
        COUNTDOWN,  // led decrements per tick
        DONE        // led flashes, done held high
    } timer_state_e;

    // one-cycle release pulses from the debouncers
    typedef struct packed {
        logic ctrl;  // start / run
        logic zero;  // shift in a 0
        logic one;   // shift in a 1
    } btn_events_t;

endpackage

// File: design/debounce.sv
////////////////////
// button synchronizer and debounce filter
// out is the filtered level, ondn/onup pulse on its falling/rising edge
////////////////////

`timescale 1ns/1ps

module debounce
    import timer_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic in,    // raw button, active low (released level is 1)
    output logic out,
    output logic ondn,
    output logic onup
);

    logic                 sync_0;
    logic                 sync_1;
    logic [DEB_CNT_W-1:0] cnt;
    logic                 differs;
    logic                 stable;

    assign differs = (sync_1 != out);
    assign stable = differs && (cnt == DEB_CNT_W'(DEB_COUNT));

    // two-flop synchronizer, resets to the released level
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end else begin
            sync_0 <= in;
            sync_1 <= sync_0;
        end
    end

    // stability counter runs only while the input disagrees with out
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            out  <= 1'b1;
            ondn <= 1'b0;
            onup <= 1'b0;
        end else begin
            ondn <= stable && !sync_1;  // filtered level falls
            onup <= stable && sync_1;   // filtered level rises
            if (!differs) begin
                cnt <= '0;  // bounced back, start over
            end else if (stable) begin
                out <= sync_1;
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/tick_gen.sv
////////////////////
// second tick and flash phase from one free-running divider
////////////////////

`timescale 1ns/1ps

module tick_gen
    import timer_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic tick,
    output logic flash_phase
);

    logic [TICK_CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == TICK_CNT_W'(TICK_DIV - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;  // one clock per wrap
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // same counter, so flashing stays in step with the ticks
    assign flash_phase = cnt[FLASH_BIT];

endmodule

// File: design/timer_fsm.sv
////////////////////
// timer state machine with the led value register
// handles default load, shift entry, countdown and the done flash
////////////////////

`timescale 1ns/1ps

module timer_fsm
    import timer_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  btn_events_t      events,
    input  logic             tick,
    input  logic             flash_phase,
    output logic [LED_W-1:0] led,
    output logic             done
);

    timer_state_e           state;
    timer_state_e           state_next;
    logic [FLASH_CNT_W-1:0] flash_cnt;
    logic                   flash_last;

    // last tick of the flash sequence
    assign flash_last = tick && (flash_cnt == FLASH_CNT_W'(1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (events.ctrl) begin
                    state_next = INIT;
                end
            end
            INIT: begin
                state_next = SET_TIME;
            end
            SET_TIME: begin
                if (events.ctrl) begin
                    state_next = COUNTDOWN;
                end
            end
            COUNTDOWN: begin
                if (led == '0) begin
                    state_next = DONE;  // also covers a zero set value
                end
            end
            DONE: begin
                if (flash_last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // led value, events outside SET_TIME are simply ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            led <= '0;
        end else begin
            case (state)
                INIT: begin
                    led <= DEF_TIME;
                end
                SET_TIME: begin
                    if (events.zero) begin
                        led <= {led[LED_W-2:0], 1'b0};  // oldest bit drops off
                    end else if (events.one) begin
                        led <= {led[LED_W-2:0], 1'b1};
                    end
                end
                COUNTDOWN: begin
                    if (tick && led != '0) begin
                        led <= led - 1'b1;
                    end
                end
                DONE: begin
                    if (state_next == IDLE) begin
                        led <= '0;  // dark again in idle
                    end else begin
                        led <= {LED_W{flash_phase}};
                    end
                end
                default: begin
                    led <= '0;
                end
            endcase
        end
    end

    // flash tick count, armed before DONE is entered
    always_ff @(posedge clk) begin
        if (reset) begin
            flash_cnt <= '0;
        end else if (state == COUNTDOWN) begin
            flash_cnt <= FLASH_CNT_W'(FLASH_TICKS);
        end else if (state == DONE && tick) begin
            flash_cnt <= flash_cnt - 1'b1;
        end
    end

    // high for exactly the DONE state
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= (state_next == DONE);
        end
    end

endmodule

// File: design/countdown_timer.sv
////////////////////
// countdown timer top, three buttons in and four leds out
// buttons are active low, a release raises the filtered level
////////////////////

`timescale 1ns/1ps

module countdown_timer
    import timer_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             btn_ctrl,
    input  logic             btn_0,
    input  logic             btn_1,
    output logic [LED_W-1:0] led,
    output logic             done
);

    btn_events_t events;       // release pulses, one field per button
    logic        tick;
    logic        flash_phase;

    // only onup is used, the level and ondn stay open
    debounce u_deb_ctrl (
        .clk   (clk),
        .reset (reset),
        .in    (btn_ctrl),
        .out   (),
        .ondn  (),
        .onup  (events.ctrl)
    );

    debounce u_deb_0 (
        .clk   (clk),
        .reset (reset),
        .in    (btn_0),
        .out   (),
        .ondn  (),
        .onup  (events.zero)
    );

    debounce u_deb_1 (
        .clk   (clk),
        .reset (reset),
        .in    (btn_1),
        .out   (),
        .ondn  (),
        .onup  (events.one)
    );

    tick_gen u_tick (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .flash_phase (flash_phase)
    );

    timer_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .events      (events),
        .tick        (tick),
        .flash_phase (flash_phase),
        .led         (led),
        .done        (done)
    );

endmodule

// File: testbench/countdown_timer_tb.sv
////////////////////
// testbench for the countdown timer top level
// runs the operations listed in timer_stimulus.txt against a small model
////////////////////

`timescale 1ns/1ps

module countdown_timer_tb
    import timer_pkg::*;
;

    localparam string STIM_FILE = "testbench/timer_stimulus.txt";

    logic             clk;
    logic             reset;
    logic             btn_ctrl;
    logic             btn_0;
    logic             btn_1;
    logic [LED_W-1:0] led;
    logic             done;

    // stimulus lines, one entry per operation
    string       op_q[$];
    int          arg_q[$];
    logic [31:0] exp_q[$];
    string       name_q[$];

    int errors = 0;
    int failed_tests = 0;
    int budget_clocks = 0;

    // reference model of the timer
    timer_state_e     m_state = IDLE;
    logic [LED_W-1:0] m_led = '0;
    bit               counting = 1'b0;  // model is in COUNTDOWN
    logic [LED_W-1:0] prev_led = '0;

    int done_clocks = 0;  // negedges seen with done high
    int lit_clocks = 0;   // of those, with the leds lit
    int done_mark = 0;
    int lit_mark = 0;

    countdown_timer u_dut (
        .clk      (clk),
        .reset    (reset),
        .btn_ctrl (btn_ctrl),
        .btn_0    (btn_0),
        .btn_1    (btn_1),
        .led      (led),
        .done     (done)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int tol);
        int diff;
        diff = int'(actual) - int'(expected);
        if (diff > tol || diff < -tol) begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    // buttons are active low, 1 is released
    task automatic set_button(input int idx, input logic level);
        case (idx)
            0: btn_ctrl = level;
            1: btn_0 = level;
            default: btn_1 = level;
        endcase
    endtask

    task automatic press_button(input int idx);
        set_button(idx, 1'b0);
        repeat (2 * DEB_COUNT) @(negedge clk);
        set_button(idx, 1'b1);  // the release is the event
        repeat (2 * DEB_COUNT) @(negedge clk);
    endtask

    // short glitches, each well under DEB_COUNT clocks
    task automatic bounce_button(input int idx);
        repeat (3) begin
            set_button(idx, 1'b0);
            repeat (DEB_COUNT / 2) @(negedge clk);
            set_button(idx, 1'b1);
            repeat (DEB_COUNT / 2) @(negedge clk);
        end
        repeat (2 * DEB_COUNT) @(negedge clk);
    endtask

    task automatic wait_level(input logic level, input int limit_ticks, input string name);
        int n;
        n = 0;
        while (done !== level && n < limit_ticks * TICK_DIV) begin
            @(negedge clk);
            n++;
        end
        if (done !== level) begin
            $display("%s: done did not reach %0b within %0d ticks", name, level, limit_ticks);
            errors++;
        end
    endtask

    // one DONE phase since the last call, FLASH_TICKS ticks long with the leds lit
    task automatic check_flash(input string name);
        int len;
        len = done_clocks - done_mark;
        if (len <= (FLASH_TICKS - 1) * TICK_DIV || len > FLASH_TICKS * TICK_DIV) begin
            $display("%s: done stayed high for %0d clocks, not %0d ticks",
                     name, len, FLASH_TICKS);
            errors++;
        end
        if (lit_clocks == lit_mark) begin
            $display("%s: the leds never lit while done was high", name);
            errors++;
        end
        done_mark = done_clocks;
        lit_mark = lit_clocks;
    endtask

    task automatic model_press(input int idx);
        case (m_state)
            IDLE: begin
                if (idx == 0) begin
                    m_state = SET_TIME;  // INIT lasts one clock
                    m_led = DEF_TIME;
                end
            end
            SET_TIME: begin
                if (idx == 0) begin
                    m_state = (m_led == '0) ? DONE : COUNTDOWN;
                end else begin
                    m_led = {m_led[LED_W-2:0], (idx == 2) ? 1'b1 : 1'b0};
                end
            end
            default: ;  // dropped
        endcase
        counting = (m_state == COUNTDOWN);
    endtask

    task automatic model_ticks(input int n);
        if (m_state == COUNTDOWN) begin
            if (n >= int'(m_led)) begin
                m_led = '0;
            end else begin
                m_led = m_led - LED_W'(n);
            end
        end
    endtask

    function automatic int op_clocks(input string op, input int arg);
        case (op)
            "press": return 4 * DEB_COUNT;
            "bounce": return 5 * DEB_COUNT;
            "ticks", "wait_done", "wait_idle": return arg * TICK_DIV;
            default: return 0;
        endcase
    endfunction

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          n;
        int          arg;
        logic [31:0] exp;
        string       line;
        string       op;
        string       name;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %d %h %s", op, arg, exp, name);
                if (n == 4 && op != "#") begin
                    op_q.push_back(op);
                    arg_q.push_back(arg);
                    exp_q.push_back(exp);
                    name_q.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input int i);
        string       name;
        int          arg;
        logic [31:0] exp;
        name = name_q[i];
        arg = arg_q[i];
        exp = exp_q[i];
        case (op_q[i])
            "press": begin
                press_button(arg);
                model_press(arg);
            end
            "bounce": bounce_button(arg);
            "ticks": begin
                repeat (arg * TICK_DIV) @(negedge clk);
                model_ticks(arg);
            end
            "led": begin
                check_value({name, " model"}, 32'(m_led), exp, 0);
                check_value(name, exp, 32'(led), arg);  // arg is the tolerance
            end
            "done": begin
                check_value({name, " model"}, 32'(m_state == DONE), exp, 0);
                check_value(name, exp, 32'(done), 0);
            end
            "wait_done": begin
                wait_level(1'b1, arg, name);
                m_state = DONE;
                counting = 1'b0;
                check_value(name, exp, 32'(done), 0);
            end
            "wait_idle": begin
                wait_level(1'b0, arg, name);
                check_flash(name);
                m_state = IDLE;
                m_led = '0;
                check_value({name, " model"}, 32'(m_led), exp, 0);
                check_value(name, exp, 32'(led), 0);
            end
            default: begin
                $display("%s: unknown operation %s in the stimulus file", name, op_q[i]);
                errors++;
            end
        endcase
    endtask

    // flash levels and monotonic countdown, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset) begin
            if (done === 1'b1) begin
                done_clocks++;
                if (led != '0) begin
                    lit_clocks++;
                    check_value("flash level", 32'({LED_W{1'b1}}), 32'(led), 0);  // all or none
                end
            end else if (counting && led > prev_led) begin
                check_value("no increase", 32'(prev_led), 32'(led), 0);
            end
            prev_led <= led;
        end
    end

    initial begin
        wait (budget_clocks > 0);
        repeat (budget_clocks + budget_clocks / 2) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d clocks", budget_clocks * 3 / 2);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        bit ok;
        int errors_before;
        int total;
        clk = 1'b0;
        reset = 1'b1;
        btn_ctrl = 1'b1;
        btn_0 = 1'b1;
        btn_1 = 1'b1;
        load_stimulus(ok);
        if (!ok || op_q.size() == 0) begin
            $display("could not read any operation from %s", STIM_FILE);
            errors++;
        end else begin
            total = 4;
            foreach (op_q[i]) begin
                total += op_clocks(op_q[i], arg_q[i]);
            end
            budget_clocks = total;
            repeat (4) @(negedge clk);
            reset = 1'b0;
            for (int i = 0; i < op_q.size(); i++) begin
                errors_before = errors;
                run_op(i);
                if (errors != errors_before) begin
                    failed_tests++;
                end
                $display("test %s: %s (model %s)", name_q[i],
                         (errors == errors_before) ? "ok" : "FAIL", m_state.name());
            end
        end
        $display("%0d tests, %0d failed, %0d check errors", op_q.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: testbench/timer_stimulus.txt
# columns: op arg expected(hex) name
# press/bounce arg 0 ctrl 1 zero 2 one, led arg is tolerance, wait_* arg is a limit in ticks
led        0  0  reset_led
done       0  0  reset_done
press      1  0  idle_zero
press      2  0  idle_one
led        0  0  idle_led_dark
press      0  0  start_entry
led        0  8  default_time
press      2  0  shift_1a
press      1  0  shift_0
press      2  0  shift_1b
press      2  0  shift_1c
press      2  0  shift_1d
led        0  7  shifted_0111
bounce     0  0  bounce_ctrl
bounce     1  0  bounce_zero
bounce     2  0  bounce_one
led        0  7  bounce_no_change
press      0  0  start_count
ticks      3  0  count_3_ticks
led        1  4  count_led
done       0  0  count_not_done
wait_done  6  1  count_done
wait_idle  5  0  flash_end
done       0  0  idle_done_low
press      0  0  restart_entry
press      1  0  zero_shift
led        0  0  zero_set
press      0  0  zero_start
done       0  1  zero_done_at_once
wait_idle  5  0  zero_flash_end

// File: tb.f
design/timer_pkg.sv
design/debounce.sv
design/tick_gen.sv
design/timer_fsm.sv
design/countdown_timer.sv
testbench/countdown_timer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the countdown timer testbench with Verilator and runs it into sim.log
# exits non-zero unless the log holds the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module countdown_timer_tb -o countdown_timer_sim -f tb.f \
    && ./obj_dir/countdown_timer_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "^Finished with no errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
